//--- include/mdioRegs_params.svh
// widths, register word indices and bus response codes for the MDIO register block
// include wherever a width, index or response code is needed

`ifndef MDIO_REGS_PARAMS_SVH
`define MDIO_REGS_PARAMS_SVH

// bus widths
`define AXI_ADDR_W   32
`define AXI_DATA_W   32

// word index taken from byte address bits [7:2]
`define REG_IDX_LSB  2
`define REG_IDX_W    6

// MDIO side widths
`define PHY_DATA_W   16
`define MDIO_FIELD_W 5

// software registers
`define IDX_USR_CTRL  6'h20
`define IDX_USR_WRITE 6'h21

// ==============================
// PHY shadow indices, word index equals MDIO register number
// ==============================
`define PHY_IDX_BASIC_CTRL 6'h00
`define PHY_IDX_BASIC_STAT 6'h01
`define PHY_IDX_IDENT_1    6'h02
`define PHY_IDX_IDENT_2    6'h03
`define PHY_IDX_ANEG_ADV   6'h04
`define PHY_IDX_ANEG_LP    6'h05
`define PHY_IDX_ANEG_EXP   6'h06
`define PHY_IDX_MODE_CTRL  6'h11
`define PHY_IDX_SPEC_MODES 6'h12
`define PHY_IDX_SYM_ERR    6'h1A
`define PHY_IDX_INDICATION 6'h1B
`define PHY_IDX_INTR_SRC   6'h1D
`define PHY_IDX_INTR_MASK  6'h1E
`define PHY_IDX_SPEC_CTRL  6'h1F

// AXI response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

//--- logic/mdioRegsPkg.sv
// shared types for the MDIO register block
// modules pull these in with a wildcard import in their header

`include "mdioRegs_params.svh"

package mdioRegsPkg;

  // register word index, from the bus address
  typedef logic [`REG_IDX_W-1:0] regIdxT;

  // one MDIO register value
  typedef logic [`PHY_DATA_W-1:0] phyDataT;

  // PHY or register address field on the MDIO side
  typedef logic [`MDIO_FIELD_W-1:0] mdioFieldT;

  // ==============================
  // control word layout
  // ==============================
  // bit 0 enable, bit 1 write (1) or read (0)
  typedef struct packed {
    logic [`AXI_DATA_W-2*`MDIO_FIELD_W-3:0] unused;
    mdioFieldT                               regAddr;
    mdioFieldT                               phyAddr;
    logic                                    isWrite;
    logic                                    enable;
  } mdioCtrlFieldsT;

  // raw view for the bus, field view for the MDIO request
  typedef union packed {
    logic [`AXI_DATA_W-1:0] raw;
    mdioCtrlFieldsT         fields;
  } mdioCtrlU;

endpackage

//--- logic/regBusIf.sv
// register access bus between the AXI4-Lite slave and the register file
// slave side drives the access, register file side answers combinationally

`timescale 1ns/1ps
`include "mdioRegs_params.svh"

interface regBusIf import mdioRegsPkg::*; ();

  // write path, commits on the edge where wrEn is high
  logic                   wrEn;
  regIdxT                 wrIdx;
  logic [`AXI_DATA_W-1:0] wrData;
  // high when wrIdx is not writable
  logic                   wrErr;

  // read path
  regIdxT                 rdIdx;
  logic [`AXI_DATA_W-1:0] rdData;

  modport slave (
    output wrEn, wrIdx, wrData, rdIdx,
    input  wrErr, rdData
  );

  modport regFile (
    input  wrEn, wrIdx, wrData, rdIdx,
    output wrErr, rdData
  );

endinterface

//--- logic/phyShadowRegs.sv
// shadow copies of the implemented PHY registers
// loaded from engine reports, read back by word index

`timescale 1ns/1ps
`include "mdioRegs_params.svh"

module phyShadowRegs import mdioRegsPkg::*; (
  input  logic      axiClk,
  input  logic      rstN,
  // engine report
  input  mdioFieldT phyRegAddr,
  input  logic      phyDataValid,
  input  phyDataT   phyData,
  // read port
  input  regIdxT    rdIdx,
  output phyDataT   rdData,
  output logic      rdHit
);

  localparam int numPhyRegs = 14;

  // word index of each implemented register
  localparam regIdxT phyIdxTable [numPhyRegs] = '{
    `PHY_IDX_BASIC_CTRL, `PHY_IDX_BASIC_STAT, `PHY_IDX_IDENT_1,
    `PHY_IDX_IDENT_2,    `PHY_IDX_ANEG_ADV,   `PHY_IDX_ANEG_LP,
    `PHY_IDX_ANEG_EXP,   `PHY_IDX_MODE_CTRL,  `PHY_IDX_SPEC_MODES,
    `PHY_IDX_SYM_ERR,    `PHY_IDX_INDICATION, `PHY_IDX_INTR_SRC,
    `PHY_IDX_INTR_MASK,  `PHY_IDX_SPEC_CTRL
  };

  phyDataT shadowQ [numPhyRegs];

  // ==============================
  // load on matching report
  // ==============================
  // unimplemented addresses match nothing and are dropped
  always_ff @(posedge axiClk) begin
    if (!rstN) begin
      for (int i = 0; i < numPhyRegs; i++) begin
        shadowQ[i] <= '0;
      end
    end else if (phyDataValid) begin
      for (int i = 0; i < numPhyRegs; i++) begin
        if (regIdxT'(phyRegAddr) == phyIdxTable[i]) begin
          shadowQ[i] <= phyData;
        end
      end
    end
  end

  // read select plus hit for the register file mux
  always_comb begin
    rdData = '0;
    rdHit  = 1'b0;
    for (int i = 0; i < numPhyRegs; i++) begin
      if (rdIdx == phyIdxTable[i]) begin
        rdData = shadowQ[i];
        rdHit  = 1'b1;
      end
    end
  end

  // engine must present a clean address with each report
  aRptAddrKnown : assert property (@(posedge axiClk) disable iff (!rstN)
    phyDataValid |-> !$isunknown(phyRegAddr));

endmodule

//--- logic/mdioRegFile.sv
// software registers and read mux for the MDIO register block
// drives the MDIO request from the control and write words

`timescale 1ns/1ps
`include "mdioRegs_params.svh"

module mdioRegFile import mdioRegsPkg::*; (
  input  logic      axiClk,
  input  logic      rstN,
  // engine reports
  input  mdioFieldT phyRegAddr,
  input  logic      phyDataValid,
  input  phyDataT   phyData,
  // register bus from the AXI slave
  regBusIf.regFile  regBus,
  // MDIO request
  output mdioFieldT mdioPhyAddr,
  output mdioFieldT mdioRegAddr,
  output logic      mdioWrite,
  output logic      mdioEn,
  output phyDataT   mdioWrData
);

  mdioCtrlU               ctrlQ;
  logic [`AXI_DATA_W-1:0] wrWordQ;
  logic                   ctrlSel;
  logic                   wrWordSel;
  phyDataT                shadowData;
  logic                   shadowHit;

  // ==============================
  // write decode
  // ==============================
  // only the two software words take writes
  assign ctrlSel      = (regBus.wrIdx == `IDX_USR_CTRL);
  assign wrWordSel    = (regBus.wrIdx == `IDX_USR_WRITE);
  assign regBus.wrErr = !(ctrlSel || wrWordSel);

  always_ff @(posedge axiClk) begin
    if (!rstN) begin
      ctrlQ.raw <= '0;
      wrWordQ   <= '0;
    end else if (regBus.wrEn && !regBus.wrErr) begin
      if (ctrlSel) begin
        ctrlQ.raw <= regBus.wrData;
      end
      if (wrWordSel) begin
        wrWordQ <= regBus.wrData;
      end
    end
  end

  // ==============================
  // MDIO request outputs
  // ==============================
  // field view of the stored word
  assign mdioRegAddr = ctrlQ.fields.regAddr;
  assign mdioPhyAddr = ctrlQ.fields.phyAddr;
  assign mdioWrite   = ctrlQ.fields.isWrite;
  assign mdioEn      = ctrlQ.fields.enable;
  // MDIO registers are 16 bits wide
  assign mdioWrData  = wrWordQ[`PHY_DATA_W-1:0];

  // PHY shadow bank
  phyShadowRegs uShadow (
    .axiClk       (axiClk),
    .rstN         (rstN),
    .phyRegAddr   (phyRegAddr),
    .phyDataValid (phyDataValid),
    .phyData      (phyData),
    .rdIdx        (regBus.rdIdx),
    .rdData       (shadowData),
    .rdHit        (shadowHit)
  );

  // ==============================
  // read mux
  // ==============================
  always_comb begin
    if (regBus.rdIdx == `IDX_USR_CTRL) begin
      regBus.rdData = ctrlQ.raw;
    end else if (regBus.rdIdx == `IDX_USR_WRITE) begin
      regBus.rdData = wrWordQ;
    end else if (shadowHit) begin
      // zero-extended shadow value
      regBus.rdData = {{(`AXI_DATA_W-`PHY_DATA_W){1'b0}}, shadowData};
    end else begin
      regBus.rdData = '0;
    end
  end

  // slave must never leave the write strobe floating
  aWrEnKnown : assert property (@(posedge axiClk) disable iff (!rstN)
    !$isunknown(regBus.wrEn));

endmodule

//--- logic/axiLiteSlave.sv
// AXI4-Lite slave handshake, one transaction at a time
// turns bus writes and reads into accesses on the register bus

`timescale 1ns/1ps
`include "mdioRegs_params.svh"

module axiLiteSlave import mdioRegsPkg::*; (
  input  logic                   axiClk,
  input  logic                   rstN,
  // write address and data
  input  logic                   awValid,
  output logic                   awReady,
  input  logic [`AXI_ADDR_W-1:0] awAddr,
  input  logic                   wValid,
  output logic                   wReady,
  input  logic [`AXI_DATA_W-1:0] wData,
  // write response
  output logic                   bValid,
  output logic [1:0]             bResp,
  input  logic                   bReady,
  // read address
  input  logic                   arValid,
  output logic                   arReady,
  input  logic [`AXI_ADDR_W-1:0] arAddr,
  // read data
  output logic                   rValid,
  output logic [`AXI_DATA_W-1:0] rData,
  output logic [1:0]             rResp,
  input  logic                   rReady,
  regBusIf.slave                 regBus
);

  typedef enum logic [1:0] {
    idle,
    writeResp,
    readResp
  } stateT;

  stateT  state;
  regIdxT rdIdxQ;
  logic   busy;
  logic   acceptWr;
  logic   acceptRd;

  // ==============================
  // accept decode
  // ==============================
  // a handshake cycle is in progress while any ready is up
  assign busy     = awReady | arReady;
  // write wins when both are pending
  assign acceptWr = (state == idle) && !busy && awValid && wValid;
  assign acceptRd = (state == idle) && !busy && !(awValid && wValid) && arValid;

  // ==============================
  // register bus side
  // ==============================
  // master holds address and data until the ready cycle
  assign regBus.wrIdx  = awAddr[`REG_IDX_LSB +: `REG_IDX_W];
  assign regBus.wrData = wData;
  // commit on the handshake edge itself
  assign regBus.wrEn   = awReady & wReady;
  assign regBus.rdIdx  = rdIdxQ;

  // ==============================
  // control FSM
  // ==============================
  always_ff @(posedge axiClk) begin
    if (!rstN) begin
      state   <= idle;
      awReady <= 1'b0;
      wReady  <= 1'b0;
      arReady <= 1'b0;
      bValid  <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      case (state)
        idle: begin
          if (awReady) begin
            // write handshake completes this cycle
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b1;
            state   <= writeResp;
          end else if (arReady) begin
            arReady <= 1'b0;
            rValid  <= 1'b1;
            state   <= readResp;
          end else if (acceptWr) begin
            awReady <= 1'b1;
            wReady  <= 1'b1;
          end else if (acceptRd) begin
            arReady <= 1'b1;
          end
        end
        writeResp: begin
          // hold response until master takes it
          if (bReady) begin
            bValid <= 1'b0;
            state  <= idle;
          end
        end
        readResp: begin
          if (rReady) begin
            rValid <= 1'b0;
            state  <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // ==============================
  // payload registers
  // ==============================
  always_ff @(posedge axiClk) begin
    if (acceptRd) begin
      rdIdxQ <= arAddr[`REG_IDX_LSB +: `REG_IDX_W];
    end
    // refused writes come back as SLVERR
    if (state == idle && awReady) begin
      bResp <= regBus.wrErr ? `RESP_SLVERR : `RESP_OKAY;
    end
    // read data frozen here until rReady
    if (state == idle && arReady) begin
      rData <= regBus.rdData;
      rResp <= `RESP_OKAY;
    end
  end

  // only one response channel active at a time
  aOneResp : assert property (@(posedge axiClk) disable iff (!rstN)
    !(bValid && rValid));

  // write response held under back-pressure
  aBValidHold : assert property (@(posedge axiClk) disable iff (!rstN)
    bValid && !bReady |=> bValid);

endmodule

//--- logic/ethMdioRegs.sv
// top level of the MDIO register block
// AXI4-Lite slave ports in, MDIO request out, engine reports in

`timescale 1ns/1ps
`include "mdioRegs_params.svh"

module ethMdioRegs import mdioRegsPkg::*; (
  input  logic                   axiClk,
  input  logic                   rstN,
  // AXI4-Lite write
  input  logic                   awValid,
  output logic                   awReady,
  input  logic [`AXI_ADDR_W-1:0] awAddr,
  input  logic                   wValid,
  output logic                   wReady,
  input  logic [`AXI_DATA_W-1:0] wData,
  output logic                   bValid,
  output logic [1:0]             bResp,
  input  logic                   bReady,
  // AXI4-Lite read
  input  logic                   arValid,
  output logic                   arReady,
  input  logic [`AXI_ADDR_W-1:0] arAddr,
  output logic                   rValid,
  output logic [`AXI_DATA_W-1:0] rData,
  output logic [1:0]             rResp,
  input  logic                   rReady,
  // engine reports
  input  mdioFieldT              phyRegAddr,
  input  logic                   phyDataValid,
  input  phyDataT                phyData,
  // MDIO request
  output mdioFieldT              mdioPhyAddr,
  output mdioFieldT              mdioRegAddr,
  output logic                   mdioWrite,
  output logic                   mdioEn,
  output phyDataT                mdioWrData
);

  regBusIf regBus ();

  // ==============================
  // bus slave
  // ==============================
  axiLiteSlave uAxiSlave (
    .axiClk  (axiClk),
    .rstN    (rstN),
    .awValid (awValid),
    .awReady (awReady),
    .awAddr  (awAddr),
    .wValid  (wValid),
    .wReady  (wReady),
    .wData   (wData),
    .bValid  (bValid),
    .bResp   (bResp),
    .bReady  (bReady),
    .arValid (arValid),
    .arReady (arReady),
    .arAddr  (arAddr),
    .rValid  (rValid),
    .rData   (rData),
    .rResp   (rResp),
    .rReady  (rReady),
    .regBus  (regBus.slave)
  );

  // register file with shadow bank inside
  mdioRegFile uRegFile (
    .axiClk       (axiClk),
    .rstN         (rstN),
    .phyRegAddr   (phyRegAddr),
    .phyDataValid (phyDataValid),
    .phyData      (phyData),
    .regBus       (regBus.regFile),
    .mdioPhyAddr  (mdioPhyAddr),
    .mdioRegAddr  (mdioRegAddr),
    .mdioWrite    (mdioWrite),
    .mdioEn       (mdioEn),
    .mdioWrData   (mdioWrData)
  );

endmodule

//--- dv/tbEthMdioRegs.sv
// testbench for the MDIO register block
// runs a table of AXI4-Lite accesses and engine reports against the DUT
// expected values come from the register map and control word layout

`timescale 1ns/1ps
`include "mdioRegs_params.svh"

module tbEthMdioRegs import mdioRegsPkg::*; ();

  typedef enum {opWrite, opRead, opReport, opMdio, opWrRd} opT;

  // one table row with a byte address
  typedef struct {
    opT          op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expData;
    logic [1:0]  expResp;
  } stepT;

  // max cycles to wait for any ready or valid
  localparam int hsLimit = 40;
  localparam logic [31:0] ctrlAddr = 32'(`IDX_USR_CTRL) << `REG_IDX_LSB;
  localparam logic [31:0] wordAddr = 32'(`IDX_USR_WRITE) << `REG_IDX_LSB;
  // regAddr 0x1B, phyAddr 5, write, enable, junk in unused bits
  localparam logic [31:0] ctrlA = 32'hABCD_0D97;
  // regAddr 0x1E, phyAddr 1, read, enable
  localparam logic [31:0] ctrlB = 32'h0000_0F05;
  localparam logic [31:0] wordA = 32'h1234_BEEF;

  logic        axiClk, rstN;
  logic        awValid, awReady, wValid, wReady, bValid, bReady;
  logic        arValid, arReady, rValid, rReady;
  logic [31:0] awAddr, wData, arAddr, rData;
  logic [1:0]  bResp, rResp;
  mdioFieldT   phyRegAddr, mdioPhyAddr, mdioRegAddr;
  logic        phyDataValid, mdioWrite, mdioEn;
  phyDataT     phyData, mdioWrData;

  stepT        steps[$];
  stepT        curStep;
  int          errors = 0;
  int          checks = 0;
  logic        tableReady = 1'b0;
  logic [1:0]  wrResp, rdResp;
  logic [31:0] rdVal;
  mdioCtrlU    ctrlExp;
  time         wrDone, rdDone;

  always #4 axiClk = ~axiClk;

  ethMdioRegs i_dut (.*);

  // ==============================
  // helpers
  // ==============================
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL time=%0t %s: got 0x%0h expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // byte address of a word index
  function automatic logic [31:0] idxAddr(input regIdxT idx);
    return 32'(idx) << `REG_IDX_LSB;
  endfunction

  task automatic addStep(input opT op, input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] expData, input logic [1:0] expResp);
    stepT s;
    s.op = op;
    s.addr = addr;
    s.data = data;
    s.expData = expData;
    s.expResp = expResp;
    steps.push_back(s);
  endtask

  task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    int cnt;
    int stall;
    @(posedge axiClk);
    #1;
    awValid = 1'b1;
    awAddr  = addr;
    wValid  = 1'b1;
    wData   = data;
    cnt = 0;
    @(negedge axiClk);
    while (!(awReady && wReady) && cnt < hsLimit) begin
      @(negedge axiClk);
      cnt++;
    end
    if (!(awReady && wReady)) begin
      errors++;
      $display("ERROR at %0t: write address and data were never accepted", $time);
    end
    // handshake completes on this edge
    @(posedge axiClk);
    #1;
    awValid = 1'b0;
    wValid  = 1'b0;
    cnt = 0;
    @(negedge axiClk);
    while (!bValid && cnt < hsLimit) begin
      @(negedge axiClk);
      cnt++;
    end
    if (!bValid) begin
      errors++;
      $display("ERROR at %0t: write response never arrived", $time);
    end
    resp = bResp;
    // response must hold under back-pressure
    stall = $urandom % 6;
    repeat (stall) begin
      @(negedge axiClk);
      checkValue("bValid", 32'(bValid), 32'd1);
      checkValue("bResp", 32'(bResp), 32'(resp));
    end
    @(posedge axiClk);
    #1 bReady = 1'b1;
    @(posedge axiClk);
    #1 bReady = 1'b0;
  endtask

  task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int cnt;
    int stall;
    @(posedge axiClk);
    #1;
    arValid = 1'b1;
    arAddr  = addr;
    cnt = 0;
    @(negedge axiClk);
    while (!arReady && cnt < hsLimit) begin
      @(negedge axiClk);
      cnt++;
    end
    if (!arReady) begin
      errors++;
      $display("ERROR at %0t: read address was never accepted", $time);
    end
    @(posedge axiClk);
    #1 arValid = 1'b0;
    cnt = 0;
    @(negedge axiClk);
    while (!rValid && cnt < hsLimit) begin
      @(negedge axiClk);
      cnt++;
    end
    if (!rValid) begin
      errors++;
      $display("ERROR at %0t: read data never arrived", $time);
    end
    data = rData;
    resp = rResp;
    // rData frozen while rReady is low
    stall = $urandom % 6;
    repeat (stall) begin
      @(negedge axiClk);
      checkValue("rValid", 32'(rValid), 32'd1);
      checkValue("rData", rData, data);
    end
    @(posedge axiClk);
    #1 rReady = 1'b1;
    @(posedge axiClk);
    #1 rReady = 1'b0;
  endtask

  // one-cycle engine report strobe
  task automatic phyReport(input logic [31:0] addr, input logic [31:0] data);
    @(posedge axiClk);
    #1;
    phyRegAddr   = addr[`REG_IDX_LSB +: `MDIO_FIELD_W];
    phyData      = data[`PHY_DATA_W-1:0];
    phyDataValid = 1'b1;
    @(posedge axiClk);
    #1 phyDataValid = 1'b0;
  endtask

  // ==============================
  // stimulus table
  // ==============================
  task automatic buildTable();
    // reset values
    addStep(opRead, ctrlAddr, 0, 0, `RESP_OKAY);
    addStep(opRead, wordAddr, 0, 0, `RESP_OKAY);
    addStep(opRead, idxAddr(`PHY_IDX_BASIC_STAT), 0, 0, `RESP_OKAY);
    addStep(opMdio, 0, 0, 0, 0);
    // software registers
    addStep(opWrite, ctrlAddr, ctrlA, 0, `RESP_OKAY);
    addStep(opWrite, wordAddr, wordA, 0, `RESP_OKAY);
    addStep(opRead, ctrlAddr, 0, ctrlA, `RESP_OKAY);
    addStep(opRead, wordAddr, 0, wordA, `RESP_OKAY);
    addStep(opMdio, 0, ctrlA, wordA, 0);
    // shadow loads leave neighbours at zero
    addStep(opReport, idxAddr(`PHY_IDX_IDENT_1), 32'h8022, 0, 0);
    addStep(opRead, idxAddr(`PHY_IDX_IDENT_1), 0, 32'h0000_8022, `RESP_OKAY);
    addStep(opRead, idxAddr(`PHY_IDX_IDENT_2), 0, 0, `RESP_OKAY);
    addStep(opReport, idxAddr(`PHY_IDX_SPEC_CTRL), 32'hF00D, 0, 0);
    addStep(opRead, idxAddr(`PHY_IDX_SPEC_CTRL), 0, 32'h0000_F00D, `RESP_OKAY);
    addStep(opRead, idxAddr(`PHY_IDX_INTR_MASK), 0, 0, `RESP_OKAY);
    addStep(opReport, idxAddr(`PHY_IDX_MODE_CTRL), 32'h5A5A, 0, 0);
    addStep(opRead, idxAddr(`PHY_IDX_MODE_CTRL), 0, 32'h0000_5A5A, `RESP_OKAY);
    // unimplemented report address
    addStep(opReport, idxAddr(6'h0C), 32'hDEAD, 0, 0);
    addStep(opRead, idxAddr(6'h0C), 0, 0, `RESP_OKAY);
    // refused writes
    addStep(opWrite, idxAddr(`PHY_IDX_IDENT_1), 32'hFFFF_FFFF, 0, `RESP_SLVERR);
    addStep(opRead, idxAddr(`PHY_IDX_IDENT_1), 0, 32'h0000_8022, `RESP_OKAY);
    addStep(opWrite, idxAddr(6'h3F), 32'h1111_1111, 0, `RESP_SLVERR);
    addStep(opRead, idxAddr(`PHY_IDX_SPEC_CTRL), 0, 32'h0000_F00D, `RESP_OKAY);
    addStep(opWrite, idxAddr(6'h22), 32'h2222_2222, 0, `RESP_SLVERR);
    addStep(opRead, ctrlAddr, 0, ctrlA, `RESP_OKAY);
    addStep(opRead, wordAddr, 0, wordA, `RESP_OKAY);
    addStep(opMdio, 0, ctrlA, wordA, 0);
    // write and read together with the write first
    addStep(opWrRd, ctrlAddr, ctrlB, ctrlB, `RESP_OKAY);
    addStep(opMdio, 0, ctrlB, wordA, 0);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    void'($urandom(24086));
    axiClk = 1'b0;
    rstN = 1'b0;
    awValid = 1'b0;
    awAddr = '0;
    wValid = 1'b0;
    wData = '0;
    bReady = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    rReady = 1'b0;
    phyRegAddr = '0;
    phyDataValid = 1'b0;
    phyData = '0;
    buildTable();
    tableReady = 1'b1;
    repeat (3) @(posedge axiClk);
    #1 rstN = 1'b1;
    @(negedge axiClk);
    // all handshake outputs idle after reset
    checkValue("awReady", 32'(awReady), 0);
    checkValue("wReady", 32'(wReady), 0);
    checkValue("arReady", 32'(arReady), 0);
    checkValue("bValid", 32'(bValid), 0);
    checkValue("rValid", 32'(rValid), 0);
    foreach (steps[i]) begin
      curStep = steps[i];
      case (curStep.op)
        opWrite: begin
          axiWrite(curStep.addr, curStep.data, wrResp);
          checkValue("bResp", 32'(wrResp), 32'(curStep.expResp));
        end
        opRead: begin
          axiRead(curStep.addr, rdVal, rdResp);
          checkValue("rData", rdVal, curStep.expData);
          checkValue("rResp", 32'(rdResp), 32'(curStep.expResp));
        end
        opReport: phyReport(curStep.addr, curStep.data);
        opMdio: begin
          // field view of the expected control word
          ctrlExp.raw = curStep.data;
          @(negedge axiClk);
          checkValue("mdioRegAddr", 32'(mdioRegAddr), 32'(ctrlExp.fields.regAddr));
          checkValue("mdioPhyAddr", 32'(mdioPhyAddr), 32'(ctrlExp.fields.phyAddr));
          checkValue("mdioWrite", 32'(mdioWrite), 32'(ctrlExp.fields.isWrite));
          checkValue("mdioEn", 32'(mdioEn), 32'(ctrlExp.fields.enable));
          checkValue("mdioWrData", 32'(mdioWrData), 32'(curStep.expData[15:0]));
        end
        default: begin
          fork
            begin
              axiWrite(curStep.addr, curStep.data, wrResp);
              wrDone = $time;
            end
            begin
              axiRead(curStep.addr, rdVal, rdResp);
              rdDone = $time;
            end
          join
          checkValue("bResp", 32'(wrResp), 32'(curStep.expResp));
          checkValue("rData", rdVal, curStep.expData);
          checkValue("rResp", 32'(rdResp), 32'(`RESP_OKAY));
          checkValue("writeBeforeRead", 32'(wrDone < rdDone), 32'd1);
        end
      endcase
    end
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog sized from the table
  initial begin
    int watchLimit;
    wait (tableReady);
    watchLimit = steps.size() * 20 + 100;
    repeat (watchLimit) @(posedge axiClk);
    $display("ERROR: run did not finish within %0d cycles", watchLimit);
    $display("checks: %0d errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
logic/mdioRegsPkg.sv
logic/regBusIf.sv
logic/phyShadowRegs.sv
logic/mdioRegFile.sv
logic/axiLiteSlave.sv
logic/ethMdioRegs.sv
dv/tbEthMdioRegs.sv

//--- Makefile
# Verilator flow for the MDIO register block
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TB_TOP    ?= tbEthMdioRegs
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: build
	@out="$$($(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
